/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= cart_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out=$$(./$(OBJ_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "^NO ERRORS$$"

clean:
	rm -rf $(OBJ_DIR)

/* sim/cart_assertions.sv */
`timescale 1ns/1ps

module cart_assertions
   import cart_pkg::*;
(
   input logic      CLK,
   input logic      rst_n,
   input snes_req_t snes_req,
   input logic      snes_rvalid,
   input logic      PSEL,
   input logic      PENABLE,
   input logic      PREADY,
   input logic      PSLVERR
);

   logic strobe;
   int   fail_count = 0;

   assign strobe = snes_req.rd | snes_req.wr;

   // Strobe edge, memory read, latch load, then valid
   a_rvalid_timing: assert property (@(posedge CLK) disable iff (!rst_n)
      snes_req.rd |-> ##3 snes_rvalid)
   else begin
      fail_count++;
      $error("console read valid late or missing");
   end

   a_rvalid_source: assert property (@(posedge CLK) disable iff (!rst_n)
      snes_rvalid |-> $past(snes_req.rd, 3))
   else begin
      fail_count++;
      $error("console valid without a read");
   end

   a_ready_access: assert property (@(posedge CLK) disable iff (!rst_n)
      PREADY |-> (PSEL && PENABLE))
   else begin
      fail_count++;
      $error("PREADY outside an access phase");
   end

   a_err_ready: assert property (@(posedge CLK) disable iff (!rst_n)
      PSLVERR |-> PREADY)
   else begin
      fail_count++;
      $error("PSLVERR without PREADY");
   end

   a_strobe_gap: assert property (@(posedge CLK) disable iff (!rst_n)
      strobe |=> !strobe [*3])
   else begin
      fail_count++;
      $error("console strobes too close together");
   end

endmodule

/* sim/cart_tb.sv */
`timescale 1ns/1ps

module cart_tb
   import cart_pkg::*;
();

   localparam int MAX_CYCLES = 4000;

   logic      CLK;
   logic      rst_n;
   snes_req_t snes_req;
   byte_t     snes_rdata;
   logic      snes_rvalid;
   logic      PSEL;
   logic      PENABLE;
   logic      PWRITE;
   apb_addr_t PADDR;
   apb_data_t PWDATA;
   apb_data_t PRDATA;
   logic      PREADY;
   logic      PSLVERR;

   byte_t       model [512];
   logic [31:0] seed;
   int          cycles;

   cart_top cart_inst (.*);

   bind cart_top cart_assertions u_assertions (.*);

   initial begin
      CLK = 1'b0;
      forever #10 CLK = ~CLK;
   end

   ////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////

   function automatic byte_t lcg_byte();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed[23:16];
   endfunction

   task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("FAIL time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
         $display("ERRORS FOUND");
         $fatal(1);
      end
   endtask

   task automatic apb_xfer(input logic wr, input apb_addr_t a, input apb_data_t d,
                           output apb_data_t rdata, output logic err);
      @(posedge CLK);
      PSEL    <= 1'b1;
      PENABLE <= 1'b0;
      PWRITE  <= wr;
      PADDR   <= a;
      PWDATA  <= d;
      @(posedge CLK);
      PENABLE <= 1'b1;
      // Wait states until the port is ready
      do
         @(negedge CLK);
      while (!PREADY);
      rdata = PRDATA;
      err   = PSLVERR;
      @(posedge CLK);
      PSEL    <= 1'b0;
      PENABLE <= 1'b0;
   endtask

   task automatic apb_write(input apb_addr_t a, input apb_data_t d);
      apb_data_t rdata;
      logic      err;
      apb_xfer(1'b1, a, d, rdata, err);
      check_eq("PSLVERR", 32'(err), 32'd0);
   endtask

   task automatic apb_read(input apb_addr_t a, output apb_data_t d);
      logic err;
      apb_xfer(1'b0, a, '0, d, err);
      check_eq("PSLVERR", 32'(err), 32'd0);
   endtask

   task automatic mcu_check_byte(input baddr_t a);
      apb_data_t d;
      apb_write(REG_ADDR, 32'(a));
      apb_read(REG_DATA, d);
      check_eq("PRDATA", d, 32'(model[a]));
   endtask

   task automatic snes_write(input baddr_t a, input byte_t d, input logic owned);
      @(posedge CLK);
      snes_req <= '{rd: 1'b0, wr: 1'b1, addr: a, wdata: d};
      @(posedge CLK);
      snes_req <= '0;
      if (!owned)
         model[a] = d;
      repeat (3) @(posedge CLK);
   endtask

   task automatic snes_read(input baddr_t a, input byte_t exp);
      int lat;
      @(posedge CLK);
      snes_req <= '{rd: 1'b1, wr: 1'b0, addr: a, wdata: 8'h00};
      @(posedge CLK);
      snes_req <= '0;
      lat = 0;
      do begin
         @(negedge CLK);
         lat++;
      end while (!snes_rvalid && lat < 6);
      // Strobe edge plus two read cycles
      check_eq("snes_rvalid latency", 32'(lat), 32'd3);
      check_eq("snes_rdata", 32'(snes_rdata), 32'(exp));
   endtask

   ////////////////////////////////////////
   // Directed tests
   ////////////////////////////////////////

   task automatic test_mcu_block();
      apb_data_t d;
      byte_t     b;
      apb_write(REG_ADDR, 32'h010);
      for (int i = 0; i < 32; i++) begin
         b = lcg_byte();
         apb_write(REG_DATA, 32'(b));
         model[9'h010 + i] = b;
      end
      apb_read(REG_ADDR, d);
      check_eq("addr register", d, 32'h030);
      apb_write(REG_ADDR, 32'h010);
      for (int i = 0; i < 32; i++) begin
         apb_read(REG_DATA, d);
         check_eq("PRDATA", d, 32'(model[9'h010 + i]));
      end
      apb_read(REG_ADDR, d);
      check_eq("addr register", d, 32'h030);
   endtask

   task automatic test_snes_lanes();
      baddr_t a;
      for (int i = 0; i < 8; i++) begin
         a = 9'h013 + 9'(i * 3);
         snes_write(a, lcg_byte(), 1'b0);
         mcu_check_byte(a);
         mcu_check_byte(a ^ 9'd1);
      end
   endtask

   task automatic test_snes_reads();
      for (int i = 0; i < 16; i++)
         snes_read(9'h010 + 9'(i), model[9'h010 + i]);
   endtask

   task automatic test_mcu_owned();
      apb_data_t d;
      byte_t     b;
      apb_write(REG_CTRL, 32'd1);
      snes_read(9'h012, 8'h00);
      snes_write(9'h012, ~model[9'h012], 1'b1);
      snes_write(9'h015, ~model[9'h015], 1'b1);
      apb_write(REG_ADDR, 32'h040);
      for (int i = 0; i < 8; i++) begin
         b = lcg_byte();
         apb_write(REG_DATA, 32'(b));
         model[9'h040 + i] = b;
      end
      apb_write(REG_ADDR, 32'h040);
      for (int i = 0; i < 8; i++) begin
         apb_read(REG_DATA, d);
         check_eq("PRDATA direct", d, 32'(model[9'h040 + i]));
      end
      snes_read(9'h041, 8'h00);
      apb_write(REG_CTRL, 32'd0);
      snes_read(9'h012, model[9'h012]);
      snes_read(9'h015, model[9'h015]);
      snes_read(9'h043, model[9'h043]);
   endtask

   // MCU access started a few cycles before a console strobe
   task automatic test_mixed();
      apb_data_t d;
      byte_t     b;
      for (int k = 0; k < 6; k++) begin
         apb_write(REG_ADDR, 32'h020 + 32'(k));
         b = lcg_byte();
         fork
            apb_write(REG_DATA, 32'(b));
            begin
               repeat (k) @(posedge CLK);
               snes_read(9'h011 + 9'(k), model[9'h011 + k]);
            end
         join
         model[9'h020 + k] = b;
         apb_write(REG_ADDR, 32'h020 + 32'(k));
         fork
            apb_read(REG_DATA, d);
            begin
               repeat (k) @(posedge CLK);
               snes_write(9'h050 + 9'(k), lcg_byte(), 1'b0);
            end
         join
         check_eq("PRDATA mixed", d, 32'(model[9'h020 + k]));
         snes_read(9'h050 + 9'(k), model[9'h050 + k]);
      end
   endtask

   task automatic test_registers();
      apb_data_t d;
      logic      err;
      apb_xfer(1'b1, 8'h0c, 32'h5a, d, err);
      check_eq("PSLVERR unmapped", 32'(err), 32'd1);
      apb_xfer(1'b0, 8'h10, '0, d, err);
      check_eq("PSLVERR unmapped", 32'(err), 32'd1);
      apb_write(REG_CTRL, 32'd1);
      apb_read(REG_CTRL, d);
      check_eq("ctrl register", d, 32'd1);
      apb_write(REG_CTRL, 32'd0);
      apb_read(REG_CTRL, d);
      check_eq("ctrl register", d, 32'd0);
   endtask

   ////////////////////////////////////////
   // Main sequence and timeout
   ////////////////////////////////////////

   initial begin
      rst_n     = 1'b0;
      snes_req  = '0;
      PSEL      = 1'b0;
      PENABLE   = 1'b0;
      PWRITE    = 1'b0;
      PADDR     = '0;
      PWDATA    = '0;
      seed      = 32'hf16e50fa;
      repeat (16) @(posedge CLK);
      rst_n <= 1'b1;
      @(negedge CLK);
      check_eq("PREADY", 32'(PREADY), 32'd0);
      check_eq("PSLVERR", 32'(PSLVERR), 32'd0);
      check_eq("snes_rvalid", 32'(snes_rvalid), 32'd0);
      test_mcu_block();
      test_snes_lanes();
      test_snes_reads();
      test_mcu_owned();
      test_mixed();
      test_registers();
      if (cart_inst.u_assertions.fail_count == 0)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

   initial begin
      cycles = 0;
      while (cycles < MAX_CYCLES) begin
         @(posedge CLK);
         cycles++;
      end
      $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("ERRORS FOUND");
      $fatal(1);
   end

endmodule

/* verilog/access_sequencer.sv */
`timescale 1ns/1ps

module access_sequencer
   import cart_pkg::*;
(
   input  logic       CLK,
   input  logic       rst_n,
   input  snes_req_t  snes_req,
   input  mcu_cmd_t   mcu_cmd,
   input  logic       mcu_owns,
   output latch_ctl_t latch_ctl,
   output mem_req_t   mem_req,
   output logic       mcu_done,
   output logic       snes_rvalid,
   output logic       snes_zero
);

   typedef enum logic [2:0] {IDLE, SNES_RD, SNES_DLY, MCU_MEM, MCU_LD} seq_state_t;

   seq_state_t state;
   seq_state_t state_nxt;
   mem_req_t   mem_q;
   wsel_t      wsel_q;
   logic       strobe;
   logic       snes_mem;
   logic       start_mcu;
   logic       lat_rd_q;
   logic       out_ld_q;
   logic       zero_q;
   logic       rvalid_q;

   assign strobe    = snes_req.rd | snes_req.wr;
   assign snes_mem  = strobe & ~mcu_owns;
   // MCU waits for a quiet cycle, console keeps fixed timing
   assign start_mcu = (state == IDLE) & mcu_cmd.req & ~strobe;

   always_comb begin
      state_nxt = state;
      case (state)
         IDLE:     if (snes_req.rd) state_nxt = SNES_RD;
                   else if (start_mcu) state_nxt = MCU_MEM;
         SNES_RD:  state_nxt = SNES_DLY;
         SNES_DLY: state_nxt = IDLE;
         MCU_MEM:  if (snes_req.rd) state_nxt = SNES_RD;
                   else if (lat_rd_q) state_nxt = MCU_LD;
                   else state_nxt = IDLE;
         MCU_LD:   state_nxt = snes_req.rd ? SNES_RD : IDLE;
         default:  state_nxt = IDLE;
      endcase
   end

   always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
         state    <= IDLE;
         mem_q    <= '0;
         wsel_q   <= WSEL_SNES;
         lat_rd_q <= 1'b0;
         out_ld_q <= 1'b0;
         zero_q   <= 1'b0;
         rvalid_q <= 1'b0;
      end else begin
         state    <= state_nxt;
         out_ld_q <= (state == MCU_MEM) & lat_rd_q;
         rvalid_q <= (state == SNES_DLY);
         if (snes_req.rd)
            zero_q <= mcu_owns;
         mem_q.en <= snes_mem | start_mcu;
         // Address fields hold between cycles so the read lane stays valid
         if (snes_mem) begin
            mem_q.we      <= snes_req.wr;
            mem_q.waddr   <= snes_req.addr[8:1];
            mem_q.lane_lo <= snes_req.addr[0];
            wsel_q        <= WSEL_SNES;
         end else if (start_mcu) begin
            mem_q.we      <= mcu_cmd.we;
            mem_q.waddr   <= mcu_cmd.addr[8:1];
            mem_q.lane_lo <= mcu_cmd.addr[0];
            wsel_q        <= mcu_owns ? WSEL_MCU_DIR : WSEL_MCU_LAT;
            lat_rd_q      <= ~mcu_cmd.we & ~mcu_owns;
         end
      end
   end

   //////////////////////////////////////////
   // Latch strobes and handshakes
   //////////////////////////////////////////

   always_comb begin
      latch_ctl.snes_in_ld  = snes_req.wr & ~mcu_owns;
      latch_ctl.snes_out_ld = (state == SNES_DLY) & ~zero_q;
      latch_ctl.mcu_in_ld   = start_mcu & mcu_cmd.we & ~mcu_owns;
      latch_ctl.mcu_out_ld  = out_ld_q;
      latch_ctl.wsel        = wsel_q;
   end

   assign mcu_done    = ((state == MCU_MEM) & ~lat_rd_q) | out_ld_q;
   assign mem_req     = mem_q;
   assign snes_rvalid = rvalid_q;
   assign snes_zero   = zero_q;

endmodule

/* verilog/cart_data_path.sv */
`timescale 1ns/1ps

module cart_data_path
   import cart_pkg::*;
(
   input  logic       CLK,
   input  logic       rst_n,
   input  byte_t      snes_wdata,
   input  byte_t      mcu_wdata,
   input  latch_ctl_t latch_ctl,
   input  logic       lane_lo,
   input  logic       snes_zero,
   input  word_t      mem_rdata,
   output byte_t      mem_wdata,
   output byte_t      snes_rdata,
   output byte_t      mcu_rbyte
);

   byte_t snes_in;
   byte_t snes_out;
   byte_t mcu_in;
   byte_t mcu_out;
   byte_t lane_byte;
   logic  rd_lane_q;

   // Read data trails the memory request by one cycle
   always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n)
         rd_lane_q <= 1'b0;
      else
         rd_lane_q <= lane_lo;
   end

   // Odd address is the low lane
   assign lane_byte = rd_lane_q ? mem_rdata[7:0] : mem_rdata[15:8];

   ////////////////////////////////////////
   // Byte latches
   ////////////////////////////////////////

   always_ff @(posedge CLK) begin
      if (latch_ctl.snes_in_ld)
         snes_in <= snes_wdata;
      if (latch_ctl.snes_out_ld)
         snes_out <= lane_byte;
      if (latch_ctl.mcu_in_ld)
         mcu_in <= mcu_wdata;
      if (latch_ctl.mcu_out_ld)
         mcu_out <= lane_byte;
   end

   always_comb begin
      case (latch_ctl.wsel)
         WSEL_MCU_LAT: mem_wdata = mcu_in;
         WSEL_MCU_DIR: mem_wdata = mcu_wdata;
         default:      mem_wdata = snes_in;
      endcase
   end

   assign snes_rdata = snes_zero ? 8'h00 : snes_out;
   // MCU bypasses its latch while it owns the memory
   assign mcu_rbyte  = (latch_ctl.wsel == WSEL_MCU_DIR) ? lane_byte : mcu_out;

endmodule

/* verilog/cart_memory.sv */
`timescale 1ns/1ps

module cart_memory
   import cart_pkg::*;
(
   input  logic     CLK,
   input  mem_req_t mem_req,
   input  byte_t    mem_wdata,
   output word_t    mem_rdata
);

   word_t mem [MEM_WORDS];
   word_t wword;

   // Same byte on both lanes, the lane bit picks which one lands
   assign wword = {mem_wdata, mem_wdata};

   ////////////////////////////////////////
   // Write port
   ////////////////////////////////////////

   always_ff @(posedge CLK) begin
      if (mem_req.en && mem_req.we) begin
         if (mem_req.lane_lo)
            mem[mem_req.waddr][7:0] <= wword[7:0];
         else
            mem[mem_req.waddr][15:8] <= wword[15:8];
      end
   end

   ////////////////////////////////////////
   // Read port
   ////////////////////////////////////////

   // Registered on every enabled cycle, old word during a write
   always_ff @(posedge CLK) begin
      if (mem_req.en)
         mem_rdata <= mem[mem_req.waddr];
   end

endmodule

/* verilog/cart_pkg.sv */
package cart_pkg;

   ////////////////////////////////////////
   // Data and address widths
   ////////////////////////////////////////

   typedef logic [7:0]  byte_t;
   typedef logic [15:0] word_t;
   // Byte address, bit 0 picks the lane
   typedef logic [8:0]  baddr_t;
   typedef logic [7:0]  waddr_t;

   localparam int MEM_WORDS = 256;

   ////////////////////////////////////////
   // APB register map
   ////////////////////////////////////////

   localparam int APB_AW = 8;
   localparam int APB_DW = 32;

   typedef logic [APB_AW-1:0] apb_addr_t;
   typedef logic [APB_DW-1:0] apb_data_t;

   localparam apb_addr_t REG_ADDR = 8'h00;
   localparam apb_addr_t REG_DATA = 8'h04;
   localparam apb_addr_t REG_CTRL = 8'h08;

   ////////////////////////////////////////
   // Write byte source select
   ////////////////////////////////////////

   typedef logic [1:0] wsel_t;

   localparam wsel_t WSEL_SNES    = 2'd0;
   localparam wsel_t WSEL_MCU_LAT = 2'd1;
   localparam wsel_t WSEL_MCU_DIR = 2'd2;

   ////////////////////////////////////////
   // Bundles between the blocks
   ////////////////////////////////////////

   typedef struct packed {
      logic   rd;
      logic   wr;
      baddr_t addr;
      byte_t  wdata;
   } snes_req_t;

   typedef struct packed {
      logic   req;
      logic   we;
      baddr_t addr;
      byte_t  wdata;
   } mcu_cmd_t;

   typedef struct packed {
      logic  snes_in_ld;
      logic  snes_out_ld;
      logic  mcu_in_ld;
      logic  mcu_out_ld;
      wsel_t wsel;
   } latch_ctl_t;

   typedef struct packed {
      logic   en;
      logic   we;
      waddr_t waddr;
      logic   lane_lo;
   } mem_req_t;

endpackage

/* verilog/cart_top.sv */
`timescale 1ns/1ps

module cart_top
   import cart_pkg::*;
(
   input  logic      CLK,
   input  logic      rst_n,
   input  snes_req_t snes_req,
   output byte_t     snes_rdata,
   output logic      snes_rvalid,
   input  logic      PSEL,
   input  logic      PENABLE,
   input  logic      PWRITE,
   input  apb_addr_t PADDR,
   input  apb_data_t PWDATA,
   output apb_data_t PRDATA,
   output logic      PREADY,
   output logic      PSLVERR
);

   mcu_cmd_t   mcu_cmd;
   logic       mcu_done;
   logic       mcu_owns;
   byte_t      mcu_rbyte;
   latch_ctl_t latch_ctl;
   mem_req_t   mem_req;
   logic       snes_zero;
   byte_t      mem_wdata;
   word_t      mem_rdata;

   // MCU register interface
   mcu_apb_port u_apb_port (
      .CLK       (CLK),
      .rst_n     (rst_n),
      .PSEL      (PSEL),
      .PENABLE   (PENABLE),
      .PWRITE    (PWRITE),
      .PADDR     (PADDR),
      .PWDATA    (PWDATA),
      .PRDATA    (PRDATA),
      .PREADY    (PREADY),
      .PSLVERR   (PSLVERR),
      .mcu_cmd   (mcu_cmd),
      .mcu_done  (mcu_done),
      .mcu_rbyte (mcu_rbyte),
      .mcu_owns  (mcu_owns)
   );

   access_sequencer u_sequencer (
      .CLK         (CLK),
      .rst_n       (rst_n),
      .snes_req    (snes_req),
      .mcu_cmd     (mcu_cmd),
      .mcu_owns    (mcu_owns),
      .latch_ctl   (latch_ctl),
      .mem_req     (mem_req),
      .mcu_done    (mcu_done),
      .snes_rvalid (snes_rvalid),
      .snes_zero   (snes_zero)
   );

   cart_data_path u_data_path (
      .CLK        (CLK),
      .rst_n      (rst_n),
      .snes_wdata (snes_req.wdata),
      .mcu_wdata  (mcu_cmd.wdata),
      .latch_ctl  (latch_ctl),
      .lane_lo    (mem_req.lane_lo),
      .snes_zero  (snes_zero),
      .mem_rdata  (mem_rdata),
      .mem_wdata  (mem_wdata),
      .snes_rdata (snes_rdata),
      .mcu_rbyte  (mcu_rbyte)
   );

   cart_memory u_memory (
      .CLK       (CLK),
      .mem_req   (mem_req),
      .mem_wdata (mem_wdata),
      .mem_rdata (mem_rdata)
   );

endmodule

/* verilog/mcu_apb_port.sv */
`timescale 1ns/1ps

module mcu_apb_port
   import cart_pkg::*;
(
   input  logic      CLK,
   input  logic      rst_n,
   input  logic      PSEL,
   input  logic      PENABLE,
   input  logic      PWRITE,
   input  apb_addr_t PADDR,
   input  apb_data_t PWDATA,
   output apb_data_t PRDATA,
   output logic      PREADY,
   output logic      PSLVERR,
   output mcu_cmd_t  mcu_cmd,
   input  logic      mcu_done,
   input  byte_t     mcu_rbyte,
   output logic      mcu_owns
);

   logic   setup;
   logic   xfer_end;
   logic   sel_addr;
   logic   sel_data;
   logic   sel_ctrl;
   logic   ready_q;
   logic   err_q;
   logic   owns_q;
   logic   req_q;
   logic   cmd_we_q;
   baddr_t addr_q;
   baddr_t cmd_addr_q;
   byte_t  cmd_wdata_q;

   assign sel_addr = (PADDR == REG_ADDR);
   assign sel_data = (PADDR == REG_DATA);
   assign sel_ctrl = (PADDR == REG_CTRL);
   assign setup    = PSEL & ~PENABLE;
   assign xfer_end = PSEL & PENABLE & ready_q;

   // Data accesses wait for the sequencer, the rest finish at once
   always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
         ready_q  <= 1'b0;
         err_q    <= 1'b0;
         req_q    <= 1'b0;
         owns_q   <= 1'b0;
         addr_q   <= '0;
      end else begin
         ready_q <= (setup & ~sel_data) | mcu_done;
         err_q   <= setup & ~(sel_addr | sel_data | sel_ctrl);
         if (setup && sel_data)
            req_q <= 1'b1;
         else if (mcu_done)
            req_q <= 1'b0;
         if (xfer_end && PWRITE && sel_ctrl)
            owns_q <= PWDATA[0];
         if (xfer_end && PWRITE && sel_addr)
            addr_q <= PWDATA[8:0];
         else if (xfer_end && sel_data)
            addr_q <= addr_q + 9'd1;
      end
   end

   // Command payload captured in the setup phase
   always_ff @(posedge CLK) begin
      if (setup && sel_data) begin
         cmd_we_q    <= PWRITE;
         cmd_addr_q  <= addr_q;
         cmd_wdata_q <= PWDATA[7:0];
      end
   end

   always_comb begin
      PRDATA = '0;
      if (sel_addr)
         PRDATA = apb_data_t'(addr_q);
      else if (sel_data)
         PRDATA = apb_data_t'(mcu_rbyte);
      else if (sel_ctrl)
         PRDATA = apb_data_t'(owns_q);
   end

   assign PREADY   = ready_q;
   assign PSLVERR  = err_q;
   assign mcu_owns = owns_q;
   assign mcu_cmd  = '{req: req_q, we: cmd_we_q, addr: cmd_addr_q, wdata: cmd_wdata_q};

endmodule

/* vlog.f */
verilog/cart_pkg.sv
verilog/mcu_apb_port.sv
verilog/access_sequencer.sv
verilog/cart_data_path.sv
verilog/cart_memory.sv
verilog/cart_top.sv
sim/cart_assertions.sv
sim/cart_tb.sv
